/* Makefile */
# Verilator build and run of the ARP engine testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module arp_tb -o arp_tb_sim
	./obj_dir/arp_tb_sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/arp_asserts.sv */
// ARP engine assertions: single-cycle responses, legal frame opcodes, idle after reset
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_asserts (
    input logic               clk,
    input logic               rst,
    input logic               busy,
    input logic               rsp_valid,
    input logic               tx_valid,
    input arp_pkg::arp_oper_t tx_oper
);

    // one response strobe per lookup
    rsp_single: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
        else $error("rsp_valid stayed high for two cycles");

    tx_oper_legal: assert property (@(posedge clk) disable iff (rst)
        tx_valid |-> (tx_oper == `ARP_OPER_REQUEST || tx_oper == `ARP_OPER_REPLY))
        else $error("tx frame carries an opcode that is neither request nor reply");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else $error("busy high in the first cycle after reset");

endmodule

bind arp_top arp_asserts u_asserts (
    .clk, .rst, .busy, .rsp_valid, .tx_valid, .tx_oper
);

/* dv/arp_tb.sv */
// ARP engine testbench: table of lookups, incoming frames and cache clears
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_tb;

    localparam int LOOKUP = 0;
    localparam int FRAME  = 1;
    localparam int CLEAR  = 2;
    localparam int INJECT = 3;
    localparam int NUM_ROWS   = 12;
    localparam int ROW_CYCLES = `ARP_RETRY_COUNT * `ARP_RETRY_INTERVAL + `ARP_TIMEOUT;

    localparam arp_pkg::ipv4_t LOCAL_IP   = 32'hc0a8_010a;
    localparam arp_pkg::ipv4_t GATEWAY_IP = 32'hc0a8_0101;
    localparam arp_pkg::ipv4_t X1 = 32'hc0a8_0105;
    localparam arp_pkg::ipv4_t X2 = 32'hc0a8_0107;
    localparam arp_pkg::ipv4_t X3 = 32'hc0a8_0109;
    localparam arp_pkg::ipv4_t X4 = 32'hc0a8_0120;

    // frame fields feed incoming frames, exp_* columns hold the expected outcome
    typedef struct {
        string              name;
        int                 kind;
        arp_pkg::ipv4_t     ip;
        arp_pkg::mac_t      mac;
        arp_pkg::ipv4_t     tpa;
        arp_pkg::arp_oper_t oper;
        arp_pkg::ethtype_t  htype;
        logic               exp_err;
        arp_pkg::mac_t      exp_mac;
        int                 exp_ntx;
        arp_pkg::ipv4_t     exp_tpa;
    } row_t;

    logic               clk, rst, clear_cache, req_valid, busy, rsp_valid, rsp_error;
    logic               rx_valid, tx_valid;
    arp_pkg::mac_t      local_mac, rsp_mac, rx_eth_src_mac, rx_sha, tx_dest_mac, tx_tha;
    arp_pkg::ipv4_t     local_ip, gateway_ip, subnet_mask, req_ip, rx_spa, rx_tpa, tx_tpa;
    arp_pkg::ethtype_t  rx_eth_type, rx_htype, rx_ptype;
    arp_pkg::arp_oper_t rx_oper, tx_oper;

    row_t          rows[$];
    logic [143:0]  tx_q[$];
    int            errors, checks;
    arp_pkg::mac_t m1, m2, m3, m4;

    arp_tb_clk i_clk (.clk);

    arp_top i_arp_top (.*);

    // frame monitor
    always @(posedge clk) begin
        if (tx_valid) begin
            tx_q.push_back({tx_dest_mac, tx_oper, tx_tha, tx_tpa});
        end
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * 2 * 100);
        $display("watchdog expired before the last table row finished");
        $display("Some tests failed");
        $finish;
    end

    function automatic arp_pkg::mac_t rand_mac();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[47:0];
    endfunction

    // replies go back to the asker, their tha is the same as the destination
    // requests are broadcast with an unknown tha
    function automatic logic [143:0] expected_frame(input row_t r);
        if (r.kind == FRAME) begin
            return {~r.mac, `ARP_OPER_REPLY, ~r.mac, r.ip};
        end
        return {48'hffff_ffff_ffff, `ARP_OPER_REQUEST, 48'h0, r.exp_tpa};
    endfunction

    task automatic compare_value(input string name, input logic [143:0] exp,
                                 input logic [143:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic drive_frame(input row_t r);
        rx_valid       <= 1'b1;
        rx_eth_type    <= `ARP_ETH_TYPE;
        rx_eth_src_mac <= ~r.mac;
        rx_htype       <= r.htype;
        rx_ptype       <= `ARP_PTYPE_IPV4;
        rx_oper        <= r.oper;
        rx_sha         <= r.mac;
        rx_spa         <= r.ip;
        rx_tpa         <= r.tpa;
    endtask

    task automatic apply_row(input row_t r);
        logic          got, sent, err;
        arp_pkg::mac_t mac;
        got  = 1'b0;
        sent = 1'b0;
        err  = 1'b0;
        mac  = '0;
        tx_q.delete();
        @(posedge clk);
        if (r.kind == CLEAR) begin
            clear_cache <= 1'b1;
        end else if (r.kind == FRAME) begin
            drive_frame(r);
        end else begin
            req_valid <= 1'b1;
            req_ip    <= r.ip;
        end
        if (r.kind == LOOKUP || r.kind == INJECT) begin
            while (!got) begin
                @(posedge clk);
                req_valid <= 1'b0;
                rx_valid  <= 1'b0;
                // target answers right after its first request frame
                if (r.kind == INJECT && !sent && tx_valid) begin
                    drive_frame(r);
                    sent = 1'b1;
                end
                if (rsp_valid) begin
                    got = 1'b1;
                    err = rsp_error;
                    mac = rsp_mac;
                end
            end
        end else begin
            @(posedge clk);
            rx_valid    <= 1'b0;
            clear_cache <= 1'b0;
        end
        repeat (4) @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (got) begin
            compare_value({r.name, " rsp_error"}, 144'(r.exp_err), 144'(err));
            if (!r.exp_err) begin
                compare_value({r.name, " rsp_mac"}, 144'(r.exp_mac), 144'(mac));
            end
        end
        compare_value({r.name, " tx count"}, 144'(r.exp_ntx), 144'(tx_q.size()));
        for (int k = 0; k < tx_q.size() && k < r.exp_ntx; k++) begin
            compare_value($sformatf("%s tx frame %0d", r.name, k), expected_frame(r), tx_q[k]);
        end
    endtask

    initial begin
        void'($urandom(32'h1c20ca52));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        local_mac = rand_mac();
        local_ip = LOCAL_IP;
        gateway_ip = GATEWAY_IP;
        subnet_mask = 32'hffff_ff00;
        clear_cache = 1'b0;
        req_valid = 1'b0;
        req_ip = '0;
        rx_valid = 1'b0;
        rx_eth_type = '0;
        rx_eth_src_mac = '0;
        rx_htype = '0;
        rx_ptype = '0;
        rx_oper = '0;
        rx_sha = '0;
        rx_spa = '0;
        rx_tpa = '0;
        m1 = rand_mac();
        m2 = rand_mac();
        m3 = rand_mac();
        m4 = rand_mac();

        // name, kind, ip, mac, tpa, oper, htype, exp_err, exp_mac, exp_ntx, exp_tpa
        rows.push_back('{"limited broadcast", LOOKUP, 32'hffff_ffff, '0, '0, '0, '0,
                         1'b0, '1, 0, '0});
        rows.push_back('{"subnet broadcast", LOOKUP, 32'hc0a8_01ff, '0, '0, '0, '0,
                         1'b0, '1, 0, '0});
        rows.push_back('{"request for local ip", FRAME, X1, m1, LOCAL_IP, `ARP_OPER_REQUEST,
                         `ARP_HTYPE_ETH, 1'b0, '0, 1, '0});
        rows.push_back('{"request for other ip", FRAME, X2, m2, 32'hc0a8_0163,
                         `ARP_OPER_REQUEST, `ARP_HTYPE_ETH, 1'b0, '0, 0, '0});
        rows.push_back('{"wrong htype", FRAME, X3, m3, LOCAL_IP, `ARP_OPER_REQUEST,
                         16'h0006, 1'b0, '0, 0, '0});
        rows.push_back('{"cached lookup 1", LOOKUP, X1, '0, '0, '0, '0, 1'b0, m1, 0, '0});
        rows.push_back('{"cached lookup 2", LOOKUP, X2, '0, '0, '0, '0, 1'b0, m2, 0, '0});
        rows.push_back('{"unknown in subnet", LOOKUP, X3, '0, '0, '0, '0,
                         1'b1, '0, `ARP_RETRY_COUNT, X3});
        rows.push_back('{"off subnet", LOOKUP, 32'h0808_0808, '0, '0, '0, '0,
                         1'b1, '0, `ARP_RETRY_COUNT, GATEWAY_IP});
        rows.push_back('{"reply during retries", INJECT, X4, m4, LOCAL_IP, `ARP_OPER_REPLY,
                         `ARP_HTYPE_ETH, 1'b0, m4, 1, X4});
        rows.push_back('{"clear cache", CLEAR, '0, '0, '0, '0, '0, 1'b0, '0, 0, '0});
        rows.push_back('{"lookup after clear", LOOKUP, X1, '0, '0, '0, '0,
                         1'b1, '0, `ARP_RETRY_COUNT, X1});

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* dv/arp_tb_clk.sv */
// testbench clock source with a 100 ns period
`timescale 1ns/1ps

module arp_tb_clk (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

/* rtl/arp_cache.sv */
// ARP cache: direct-mapped IP to MAC table with one query/write port and bulk clear
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_cache (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear_cache,
    input  logic           cache_valid,
    input  logic           cache_write,
    input  arp_pkg::ipv4_t cache_ip,
    input  arp_pkg::mac_t  cache_mac_in,
    output logic           cache_rsp_valid,
    output logic           cache_hit,
    output arp_pkg::mac_t  cache_mac_out
);

    localparam int DEPTH = 1 << `ARP_CACHE_ADDR_W;

    // full IP kept as tag so aliases on the low bits never hit
    arp_pkg::ipv4_t   tag_mem [DEPTH];
    arp_pkg::mac_t    mac_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    arp_pkg::cache_idx_t idx;
    logic                wr_en;

    assign idx = cache_ip[`ARP_CACHE_ADDR_W-1:0];

    // clear wins over a write in the same cycle
    assign wr_en = cache_valid && cache_write && !clear_cache;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q         <= '0;
            cache_rsp_valid <= 1'b0;
        end else begin
            // only queries get an answer
            cache_rsp_valid <= cache_valid && !cache_write;
            if (clear_cache) begin
                valid_q <= '0;
            end else if (wr_en) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[idx] <= cache_ip;
            mac_mem[idx] <= cache_mac_in;
        end
        // a query during clear sees the emptied table
        cache_hit     <= valid_q[idx] && (tag_mem[idx] == cache_ip) && !clear_cache;
        cache_mac_out <= mac_mem[idx];
    end

endmodule

/* rtl/arp_cache_arb.sv */
// ARP cache arbiter: learning writes take priority, one colliding query is parked
`timescale 1ns/1ps

module arp_cache_arb (
    input  logic           clk,
    input  logic           rst,
    input  logic           lrn_valid,
    input  arp_pkg::ipv4_t lrn_ip,
    input  arp_pkg::mac_t  lrn_mac,
    input  logic           qry_valid,
    input  arp_pkg::ipv4_t qry_ip,
    output logic           qry_rsp_valid,
    output logic           qry_rsp_hit,
    output arp_pkg::mac_t  qry_rsp_mac,
    output logic           cache_valid,
    output logic           cache_write,
    output arp_pkg::ipv4_t cache_ip,
    output arp_pkg::mac_t  cache_mac_in,
    input  logic           cache_rsp_valid,
    input  logic           cache_hit,
    input  arp_pkg::mac_t  cache_mac_out
);

    logic           pend_q;
    arp_pkg::ipv4_t pend_ip;

    // parked query leaves on the first cycle without a write
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
        end else if (lrn_valid && qry_valid) begin
            pend_q <= 1'b1;
        end else if (!lrn_valid) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lrn_valid && qry_valid) begin
            pend_ip <= qry_ip;
        end
    end

    assign cache_valid  = lrn_valid || pend_q || qry_valid;
    assign cache_write  = lrn_valid;
    assign cache_ip     = lrn_valid ? lrn_ip : (pend_q ? pend_ip : qry_ip);
    assign cache_mac_in = lrn_mac;

    // only queries come back, so answers go straight to the resolver
    assign qry_rsp_valid = cache_rsp_valid;
    assign qry_rsp_hit   = cache_hit;
    assign qry_rsp_mac   = cache_mac_out;

endmodule

/* rtl/arp_cfg.svh */
// ARP engine configuration: cache size, retry timing and protocol constants
`ifndef ARP_CFG_SVH
`define ARP_CFG_SVH

// log2 of the number of cache entries
`define ARP_CACHE_ADDR_W    4

// request frames sent per lookup, and spacing in cycles
`define ARP_RETRY_COUNT     4
`define ARP_RETRY_INTERVAL  64
// wait after the last request frame before reporting an error
`define ARP_TIMEOUT         256
`define ARP_TIMER_W         16

`define ARP_OPER_REQUEST    16'h0001
`define ARP_OPER_REPLY      16'h0002

`define ARP_ETH_TYPE        16'h0806
`define ARP_HTYPE_ETH       16'h0001
`define ARP_PTYPE_IPV4      16'h0800

`endif

/* rtl/arp_pkg.sv */
// ARP engine types: addresses, protocol fields, cache index, timer and resolver states
`include "arp_cfg.svh"

package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;

    // ethernet type, also the ARP htype and ptype fields
    typedef logic [15:0] ethtype_t;
    typedef logic [15:0] arp_oper_t;

    typedef logic [`ARP_CACHE_ADDR_W-1:0] cache_idx_t;
    typedef logic [`ARP_TIMER_W-1:0] arp_timer_t;

    // lookup FSM
    typedef enum logic [1:0] {
        IDLE,
        QUERY,
        WAIT,
        DONE
    } res_state_t;

endpackage

/* rtl/arp_resolver.sv */
// ARP resolver: subnet decision, cache polling, request retries and timeout
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_resolver (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_valid,
    input  arp_pkg::ipv4_t req_ip,
    input  arp_pkg::ipv4_t gateway_ip,
    input  arp_pkg::ipv4_t subnet_mask,
    output logic           busy,
    output logic           rsp_valid,
    output logic           rsp_error,
    output arp_pkg::mac_t  rsp_mac,
    output logic           qry_valid,
    output arp_pkg::ipv4_t qry_ip,
    input  logic           qry_rsp_valid,
    input  logic           qry_rsp_hit,
    input  arp_pkg::mac_t  qry_rsp_mac,
    output logic           areq_valid,
    output arp_pkg::ipv4_t areq_tpa
);

    localparam int RETRY_W = $clog2(`ARP_RETRY_COUNT + 1);

    arp_pkg::res_state_t state;
    arp_pkg::arp_timer_t timer;
    arp_pkg::ipv4_t      target_ip;
    logic [RETRY_W-1:0]  retry_left;
    logic [RETRY_W-1:0]  retry_next;
    logic                qry_pend;

    logic in_subnet, is_bcast, start, do_bcast;
    logic polling, hit, miss, expired, give_up, send_req;

    // host bits all ones means subnet broadcast
    assign in_subnet = ((req_ip ^ gateway_ip) & subnet_mask) == '0;
    assign is_bcast  = (req_ip == '1) || (in_subnet && ((req_ip | subnet_mask) == '1));

    assign start    = (state == arp_pkg::IDLE) && req_valid;
    assign do_bcast = start && is_bcast;

    assign polling  = (state == arp_pkg::QUERY) || (state == arp_pkg::WAIT);
    assign hit      = polling && qry_rsp_valid && qry_rsp_hit;
    assign miss     = polling && qry_rsp_valid && !qry_rsp_hit;
    assign expired  = (state == arp_pkg::WAIT) && (timer == '0) && !hit;
    assign give_up  = expired && (retry_left == '0);
    assign send_req = ((state == arp_pkg::QUERY) && miss) || (expired && retry_left != '0);

    // frames still owed after this one
    assign retry_next = (state == arp_pkg::QUERY) ? RETRY_W'(`ARP_RETRY_COUNT - 1)
                                                  : retry_left - 1'b1;

    assign busy     = (state != arp_pkg::IDLE);
    assign qry_ip   = target_ip;
    assign areq_tpa = target_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= arp_pkg::IDLE;
            qry_valid  <= 1'b0;
            rsp_valid  <= 1'b0;
            areq_valid <= 1'b0;
            qry_pend   <= 1'b0;
            retry_left <= '0;
            timer      <= '0;
        end else begin
            qry_valid  <= 1'b0;
            rsp_valid  <= do_bcast || hit || give_up;
            areq_valid <= send_req;

            if (qry_valid) begin
                qry_pend <= 1'b1;
            end else if (qry_rsp_valid) begin
                qry_pend <= 1'b0;
            end

            case (state)
                arp_pkg::IDLE: begin
                    if (do_bcast) begin
                        state <= arp_pkg::DONE;
                    end else if (start) begin
                        qry_valid <= 1'b1;
                        state     <= arp_pkg::QUERY;
                    end
                end
                arp_pkg::QUERY: begin
                    if (hit) begin
                        state <= arp_pkg::DONE;
                    end else if (miss) begin
                        qry_valid <= 1'b1;
                        state     <= arp_pkg::WAIT;
                    end
                end
                arp_pkg::WAIT: begin
                    timer <= timer - 1'b1;
                    if (hit || give_up) begin
                        state <= arp_pkg::DONE;
                    end else if (miss) begin
                        qry_valid <= 1'b1;
                    end
                end
                default: begin
                    // let a stale query drain before taking new work
                    if (!qry_pend) begin
                        state <= arp_pkg::IDLE;
                    end
                end
            endcase

            if (send_req) begin
                retry_left <= retry_next;
                if (retry_next != '0) begin
                    timer <= arp_pkg::arp_timer_t'(`ARP_RETRY_INTERVAL - 1);
                end else begin
                    timer <= arp_pkg::arp_timer_t'(`ARP_TIMEOUT - 1);
                end
            end
        end
    end

    // off-subnet targets resolve through the gateway
    always_ff @(posedge clk) begin
        if (start) begin
            target_ip <= in_subnet ? req_ip : gateway_ip;
        end
        if (do_bcast || hit || give_up) begin
            rsp_error <= give_up;
            rsp_mac   <= do_bcast ? '1 : (hit ? qry_rsp_mac : '0);
        end
    end

endmodule

/* rtl/arp_rx_handler.sv */
// ARP receive handler: validates parsed frames, learns senders, schedules replies
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_rx_handler (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  arp_pkg::ethtype_t  rx_eth_type,
    input  arp_pkg::mac_t      rx_eth_src_mac,
    input  arp_pkg::ethtype_t  rx_htype,
    input  arp_pkg::ethtype_t  rx_ptype,
    input  arp_pkg::arp_oper_t rx_oper,
    input  arp_pkg::mac_t      rx_sha,
    input  arp_pkg::ipv4_t     rx_spa,
    input  arp_pkg::ipv4_t     rx_tpa,
    input  arp_pkg::ipv4_t     local_ip,
    output logic               lrn_valid,
    output arp_pkg::ipv4_t     lrn_ip,
    output arp_pkg::mac_t      lrn_mac,
    output logic               rep_valid,
    output arp_pkg::mac_t      rep_dest_mac,
    output arp_pkg::ipv4_t     rep_tpa
);

    logic accept;
    logic for_us;

    // ethernet over IPv4 ARP only
    assign accept = rx_valid && (rx_eth_type == `ARP_ETH_TYPE) &&
                    (rx_htype == `ARP_HTYPE_ETH) && (rx_ptype == `ARP_PTYPE_IPV4);

    assign for_us = (rx_oper == `ARP_OPER_REQUEST) && (rx_tpa == local_ip);

    always_ff @(posedge clk) begin
        if (rst) begin
            lrn_valid <= 1'b0;
            rep_valid <= 1'b0;
        end else begin
            lrn_valid <= accept;
            rep_valid <= accept && for_us;
        end
    end

    // learn from every valid frame, request or reply
    always_ff @(posedge clk) begin
        lrn_ip       <= rx_spa;
        lrn_mac      <= rx_sha;
        rep_dest_mac <= rx_eth_src_mac;
        rep_tpa      <= rx_spa;
    end

endmodule

/* rtl/arp_top.sv */
// ARP engine top level: receive handler, resolver, cache arbiter, cache and transmit select
`timescale 1ns/1ps

module arp_top (
    input  logic               clk,
    input  logic               rst,
    input  arp_pkg::mac_t      local_mac,
    input  arp_pkg::ipv4_t     local_ip,
    input  arp_pkg::ipv4_t     gateway_ip,
    input  arp_pkg::ipv4_t     subnet_mask,
    input  logic               clear_cache,
    input  logic               req_valid,
    input  arp_pkg::ipv4_t     req_ip,
    output logic               busy,
    output logic               rsp_valid,
    output logic               rsp_error,
    output arp_pkg::mac_t      rsp_mac,
    input  logic               rx_valid,
    input  arp_pkg::ethtype_t  rx_eth_type,
    input  arp_pkg::mac_t      rx_eth_src_mac,
    input  arp_pkg::ethtype_t  rx_htype,
    input  arp_pkg::ethtype_t  rx_ptype,
    input  arp_pkg::arp_oper_t rx_oper,
    input  arp_pkg::mac_t      rx_sha,
    input  arp_pkg::ipv4_t     rx_spa,
    input  arp_pkg::ipv4_t     rx_tpa,
    output logic               tx_valid,
    output arp_pkg::mac_t      tx_dest_mac,
    output arp_pkg::arp_oper_t tx_oper,
    output arp_pkg::mac_t      tx_tha,
    output arp_pkg::ipv4_t     tx_tpa
);

    // local_mac is consumed by the external framer as sender address
    logic           lrn_valid, qry_valid, qry_rsp_valid, qry_rsp_hit;
    arp_pkg::ipv4_t lrn_ip, qry_ip;
    arp_pkg::mac_t  lrn_mac, qry_rsp_mac;

    logic           cache_valid, cache_write, cache_rsp_valid, cache_hit;
    arp_pkg::ipv4_t cache_ip;
    arp_pkg::mac_t  cache_mac_in, cache_mac_out;

    logic           rep_valid, areq_valid;
    arp_pkg::mac_t  rep_dest_mac;
    arp_pkg::ipv4_t rep_tpa, areq_tpa;

    arp_rx_handler u_rx_handler (
        .clk, .rst, .rx_valid, .rx_eth_type, .rx_eth_src_mac, .rx_htype, .rx_ptype,
        .rx_oper, .rx_sha, .rx_spa, .rx_tpa, .local_ip,
        .lrn_valid, .lrn_ip, .lrn_mac, .rep_valid, .rep_dest_mac, .rep_tpa
    );

    arp_resolver u_resolver (
        .clk, .rst, .req_valid, .req_ip, .gateway_ip, .subnet_mask,
        .busy, .rsp_valid, .rsp_error, .rsp_mac, .qry_valid, .qry_ip,
        .qry_rsp_valid, .qry_rsp_hit, .qry_rsp_mac, .areq_valid, .areq_tpa
    );

    arp_cache_arb u_cache_arb (
        .clk, .rst, .lrn_valid, .lrn_ip, .lrn_mac, .qry_valid, .qry_ip,
        .qry_rsp_valid, .qry_rsp_hit, .qry_rsp_mac,
        .cache_valid, .cache_write, .cache_ip, .cache_mac_in,
        .cache_rsp_valid, .cache_hit, .cache_mac_out
    );

    arp_cache u_cache (
        .clk, .rst, .clear_cache, .cache_valid, .cache_write, .cache_ip, .cache_mac_in,
        .cache_rsp_valid, .cache_hit, .cache_mac_out
    );

    arp_tx_sel u_tx_sel (
        .clk, .rst, .rep_valid, .rep_dest_mac, .rep_tpa, .areq_valid, .areq_tpa,
        .tx_valid, .tx_dest_mac, .tx_oper, .tx_tha, .tx_tpa
    );

endmodule

/* rtl/arp_tx_sel.sv */
// ARP transmit select: merges replies and requests into one outgoing frame stream
`timescale 1ns/1ps
`include "arp_cfg.svh"

module arp_tx_sel (
    input  logic               clk,
    input  logic               rst,
    input  logic               rep_valid,
    input  arp_pkg::mac_t      rep_dest_mac,
    input  arp_pkg::ipv4_t     rep_tpa,
    input  logic               areq_valid,
    input  arp_pkg::ipv4_t     areq_tpa,
    output logic               tx_valid,
    output arp_pkg::mac_t      tx_dest_mac,
    output arp_pkg::arp_oper_t tx_oper,
    output arp_pkg::mac_t      tx_tha,
    output arp_pkg::ipv4_t     tx_tpa
);

    logic           hold_q;
    arp_pkg::ipv4_t hold_tpa;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            hold_q   <= 1'b0;
        end else begin
            tx_valid <= rep_valid || areq_valid || hold_q;
            // request stays parked while replies keep arriving
            hold_q   <= rep_valid && (areq_valid || hold_q);
        end
    end

    always_ff @(posedge clk) begin
        if (areq_valid) begin
            hold_tpa <= areq_tpa;
        end
        if (rep_valid) begin
            tx_dest_mac <= rep_dest_mac;
            tx_oper     <= `ARP_OPER_REPLY;
            tx_tha      <= rep_dest_mac;
            tx_tpa      <= rep_tpa;
        end else begin
            // broadcast request with unknown target hardware address
            tx_dest_mac <= '1;
            tx_oper     <= `ARP_OPER_REQUEST;
            tx_tha      <= '0;
            tx_tpa      <= hold_q ? hold_tpa : areq_tpa;
        end
    end

endmodule

/* src.f */
+incdir+rtl
rtl/arp_pkg.sv
rtl/arp_cache.sv
rtl/arp_cache_arb.sv
rtl/arp_rx_handler.sv
rtl/arp_resolver.sv
rtl/arp_tx_sel.sv
rtl/arp_top.sv
dv/arp_tb_clk.sv
dv/arp_asserts.sv
dv/arp_tb.sv
